// File: source/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Width of registers, ALU and memory data
`define CPU_DATA_WIDTH 8

// Shared by the ROM address and the data bus address
`define CPU_ADDR_WIDTH 8

// First instruction fetched after reset
`define CPU_RESET_PC 8'h00

// ROM address parked on while waiting for an interrupt
`define CPU_IDLE_PC 8'hF0

// Bus address driven when no memory access is in progress
`define CPU_IDLE_BUS_ADDR 8'hFF

// ROM locations holding the thread start addresses
`define CPU_VECTOR_A 8'hFF
`define CPU_VECTOR_B 8'hFE

`endif

// File: source/cpuBusPkg.sv
`include "cpu_config.svh"

package cpuBusPkg;

    //////////////////////////////
    // External port types
    //////////////////////////////

    // Byte address for both ROM and data memory
    typedef logic [`CPU_ADDR_WIDTH-1:0] addrT;

    // One data byte on the bus or in a register
    typedef logic [`CPU_DATA_WIDTH-1:0] dataT;

    // Interrupt lines
    // Bit 0 is request A and wins over bit 1
    typedef logic [1:0] irqT;

endpackage

// File: source/cpuIsaPkg.sv
package cpuIsaPkg;

    //////////////////////////////
    // Instruction set
    //////////////////////////////

    // Low nibble of an instruction byte
    typedef enum logic [3:0]
    {
        opReadA     = 4'h0,
        opReadB     = 4'h1,
        opWriteA    = 4'h2,
        opWriteB    = 4'h3,
        opMathsA    = 4'h4,
        opMathsB    = 4'h5,
        opBranch    = 4'h6,
        opGoto      = 4'h7,
        opGotoIdle  = 4'h8
    } opcodeT;

    // High nibble, only meaningful for maths and branch
    typedef enum logic [3:0]
    {
        aluAdd        = 4'h0,
        aluSub        = 4'h1,
        aluAnd        = 4'h2,
        aluOr         = 4'h3,
        aluXor        = 4'h4,
        aluShiftLeft  = 4'h5,
        aluShiftRight = 4'h6,
        aluInc        = 4'h7,
        aluDec        = 4'h8,
        aluEqual      = 4'h9,
        aluGreater    = 4'hA,
        aluLess       = 4'hB
    } aluOpT;

    typedef struct packed
    {
        aluOpT  aluOp;
        opcodeT opcode;
    } instrFieldsT;

    // Same ROM byte, seen as an instruction or as the operand after it
    typedef union packed
    {
        instrFieldsT     instr;
        cpuBusPkg::addrT operand;
    } romWordU;

    //////////////////////////////
    // Internal control
    //////////////////////////////

    typedef enum logic [2:0]
    {
        pcHold,
        pcStepOne,
        pcStepTwo,
        pcLoad,
        pcPeek,
        pcEnterIdle
    } pcCmdT;

    typedef enum logic
    {
        regSelA = 1'b0,
        regSelB = 1'b1
    } regSelT;

endpackage

// File: source/alu.sv
`timescale 1ns/1ps

module alu
(
    input  logic             CLK,
    input  logic             RESET,
    input  cpuBusPkg::dataT  regA,
    input  cpuBusPkg::dataT  regB,
    input  cpuIsaPkg::aluOpT aluOp,
    output cpuBusPkg::dataT  aluResult
);

    // Step for increment and decrement
    localparam cpuBusPkg::dataT unitStep = 1;

    cpuBusPkg::dataT nextResult;

    // Operation select
    always_comb
    begin
        case (aluOp)
            cpuIsaPkg::aluAdd:        nextResult = regA + regB;
            cpuIsaPkg::aluSub:        nextResult = regA - regB;
            cpuIsaPkg::aluAnd:        nextResult = regA & regB;
            cpuIsaPkg::aluOr:         nextResult = regA | regB;
            cpuIsaPkg::aluXor:        nextResult = regA ^ regB;
            // Shifts only look at A
            cpuIsaPkg::aluShiftLeft:  nextResult = regA << 1;
            cpuIsaPkg::aluShiftRight: nextResult = regA >> 1;
            // Wraps at the byte boundary
            cpuIsaPkg::aluInc:        nextResult = regA + unitStep;
            cpuIsaPkg::aluDec:        nextResult = regA - unitStep;
            // Compares give 01 when true, 00 otherwise
            cpuIsaPkg::aluEqual:      nextResult = cpuBusPkg::dataT'(regA == regB);
            cpuIsaPkg::aluGreater:    nextResult = cpuBusPkg::dataT'(regA > regB);
            cpuIsaPkg::aluLess:       nextResult = cpuBusPkg::dataT'(regA < regB);
            default:                  nextResult = '0;
        endcase
    end

    // Result lands one edge after the operands
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            aluResult <= '0;
        end
        else
        begin
            aluResult <= nextResult;
        end
    end

endmodule

// File: source/programCounter.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module programCounter
(
    input  logic             CLK,
    input  logic             RESET,
    input  cpuIsaPkg::pcCmdT pcCmd,
    input  cpuBusPkg::addrT  pcLoadValue,
    output cpuBusPkg::addrT  romAddress
);

    // Step sizes for one- and two-byte instructions
    localparam cpuBusPkg::addrT stepOne = 1;
    localparam cpuBusPkg::addrT stepTwo = 2;

    cpuBusPkg::addrT counter;
    // Points one byte past the instruction, at its operand
    logic            offset;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            counter <= `CPU_RESET_PC;
            offset  <= 1'b0;
        end
        else
        begin
            // Offset lives for one cycle after a peek
            offset <= (pcCmd == cpuIsaPkg::pcPeek);

            case (pcCmd)
                cpuIsaPkg::pcStepOne:   counter <= counter + stepOne;
                cpuIsaPkg::pcStepTwo:   counter <= counter + stepTwo;
                cpuIsaPkg::pcLoad:      counter <= pcLoadValue;
                // Park on the idle location
                cpuIsaPkg::pcEnterIdle: counter <= `CPU_IDLE_PC;
                // Hold and peek keep the counter
                default:                counter <= counter;
            endcase
        end
    end

    // ROM sees the counter plus the operand offset
    assign romAddress = counter + cpuBusPkg::addrT'(offset);

endmodule

// File: source/registerFile.sv
`timescale 1ns/1ps

module registerFile
(
    input  logic              CLK,
    input  logic              RESET,
    input  logic              selLoad,
    input  cpuIsaPkg::regSelT selValue,
    input  logic              regWrite,
    input  cpuBusPkg::dataT   regWriteData,
    output cpuBusPkg::dataT   regA,
    output cpuBusPkg::dataT   regB,
    output cpuBusPkg::dataT   selectedReg
);

    // Register targeted by the current instruction
    cpuIsaPkg::regSelT regSel;
    cpuIsaPkg::regSelT writeTarget;

    // A select arriving together with the write applies at once
    assign writeTarget = selLoad ? selValue : regSel;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            regSel <= cpuIsaPkg::regSelA;
            regA   <= '0;
            regB   <= '0;
        end
        else
        begin
            if (selLoad)
                regSel <= selValue;
            if (regWrite && writeTarget == cpuIsaPkg::regSelA)
                regA <= regWriteData;
            if (regWrite && writeTarget == cpuIsaPkg::regSelB)
                regB <= regWriteData;
        end
    end

    // Source for memory writes
    assign selectedReg = (regSel == cpuIsaPkg::regSelB) ? regB : regA;

endmodule

// File: source/sequencer.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module sequencer
(
    input  logic               CLK,
    input  logic               RESET,
    input  cpuIsaPkg::romWordU romData,
    input  cpuBusPkg::dataT    aluResult,
    input  cpuBusPkg::dataT    selectedReg,
    input  cpuBusPkg::dataT    busDataIn,
    input  cpuBusPkg::irqT     interruptRaise,
    output cpuIsaPkg::pcCmdT   pcCmd,
    output cpuBusPkg::addrT    pcLoadValue,
    output logic               selLoad,
    output cpuIsaPkg::regSelT  selValue,
    output logic               regWrite,
    output cpuBusPkg::dataT    regWriteData,
    output cpuBusPkg::addrT    busAddr,
    output cpuBusPkg::dataT    busDataOut,
    output logic               busWrite,
    output cpuBusPkg::irqT     interruptAck
);

    // Value of a true ALU compare
    localparam cpuBusPkg::dataT compareTrue = 1;

    // One chain of states per instruction
    typedef enum logic [4:0]
    {
        sDecode,
        sReadToA,
        sReadToB,
        sReadAddr,
        sReadWait,
        sReadStore,
        sWriteFromA,
        sWriteFromB,
        sWriteOut,
        sMathsSaveA,
        sMathsSaveB,
        sBranch,
        sBranchDecide,
        sGoto,
        sGotoLoad,
        sGotoIdle,
        sIdle,
        sThreadWait,
        sThreadLoad,
        sSettle
    } stateT;

    stateT           state;
    stateT           nextState;
    cpuBusPkg::addrT nextBusAddr;
    logic            nextBusWrite;
    cpuBusPkg::irqT  nextAck;

    //////////////////////////////
    // Next state and control
    //////////////////////////////
    always_comb
    begin
        nextState    = state;
        pcCmd        = cpuIsaPkg::pcHold;
        pcLoadValue  = romData.operand;
        selLoad      = 1'b0;
        selValue     = cpuIsaPkg::regSelA;
        regWrite     = 1'b0;
        // Bus parks between accesses
        nextBusAddr  = `CPU_IDLE_BUS_ADDR;
        nextBusWrite = 1'b0;
        nextAck      = '0;

        case (state)
            sDecode:
            begin
                // Expose the operand byte for the following cycles
                pcCmd = cpuIsaPkg::pcPeek;
                case (romData.instr.opcode)
                    cpuIsaPkg::opReadA:    nextState = sReadToA;
                    cpuIsaPkg::opReadB:    nextState = sReadToB;
                    cpuIsaPkg::opWriteA:   nextState = sWriteFromA;
                    cpuIsaPkg::opWriteB:   nextState = sWriteFromB;
                    cpuIsaPkg::opMathsA:   nextState = sMathsSaveA;
                    cpuIsaPkg::opMathsB:   nextState = sMathsSaveB;
                    cpuIsaPkg::opBranch:   nextState = sBranch;
                    cpuIsaPkg::opGoto:     nextState = sGoto;
                    cpuIsaPkg::opGotoIdle: nextState = sGotoIdle;
                    default:
                    begin
                        // Unknown code acts as a one-byte no-op
                        pcCmd     = cpuIsaPkg::pcStepOne;
                        nextState = sSettle;
                    end
                endcase
            end

            // Memory read, operand still on its way from ROM
            sReadToA:
            begin
                selLoad   = 1'b1;
                selValue  = cpuIsaPkg::regSelA;
                nextState = sReadAddr;
            end
            sReadToB:
            begin
                selLoad   = 1'b1;
                selValue  = cpuIsaPkg::regSelB;
                nextState = sReadAddr;
            end
            sReadAddr:
            begin
                nextBusAddr = romData.operand;
                nextState   = sReadWait;
            end
            // Memory is looking up the data
            sReadWait:
            begin
                pcCmd     = cpuIsaPkg::pcStepTwo;
                nextState = sReadStore;
            end
            sReadStore:
            begin
                regWrite  = 1'b1;
                nextState = sDecode;
            end

            // Memory write, step the PC early so the next fetch is ready
            sWriteFromA:
            begin
                selLoad   = 1'b1;
                selValue  = cpuIsaPkg::regSelA;
                pcCmd     = cpuIsaPkg::pcStepTwo;
                nextState = sWriteOut;
            end
            sWriteFromB:
            begin
                selLoad   = 1'b1;
                selValue  = cpuIsaPkg::regSelB;
                pcCmd     = cpuIsaPkg::pcStepTwo;
                nextState = sWriteOut;
            end
            sWriteOut:
            begin
                nextBusAddr  = romData.operand;
                nextBusWrite = 1'b1;
                nextState    = sDecode;
            end

            // ALU result from the decode cycle is ready here
            sMathsSaveA:
            begin
                selLoad   = 1'b1;
                selValue  = cpuIsaPkg::regSelA;
                regWrite  = 1'b1;
                pcCmd     = cpuIsaPkg::pcStepOne;
                nextState = sSettle;
            end
            sMathsSaveB:
            begin
                selLoad   = 1'b1;
                selValue  = cpuIsaPkg::regSelB;
                regWrite  = 1'b1;
                pcCmd     = cpuIsaPkg::pcStepOne;
                nextState = sSettle;
            end

            sBranch:
                nextState = sBranchDecide;
            // Target on the ROM port, compare on the ALU output
            sBranchDecide:
            begin
                if (aluResult == compareTrue)
                    pcCmd = cpuIsaPkg::pcLoad;
                else
                    pcCmd = cpuIsaPkg::pcStepTwo;
                nextState = sSettle;
            end

            sGoto:
                nextState = sGotoLoad;
            sGotoLoad:
            begin
                pcCmd     = cpuIsaPkg::pcLoad;
                nextState = sSettle;
            end

            sGotoIdle:
            begin
                pcCmd     = cpuIsaPkg::pcEnterIdle;
                nextState = sIdle;
            end

            // Wait for work, A has priority
            sIdle:
            begin
                if (interruptRaise[0])
                begin
                    pcCmd       = cpuIsaPkg::pcLoad;
                    pcLoadValue = `CPU_VECTOR_A;
                    nextAck     = 2'b01;
                    nextState   = sThreadWait;
                end
                else if (interruptRaise[1])
                begin
                    pcCmd       = cpuIsaPkg::pcLoad;
                    pcLoadValue = `CPU_VECTOR_B;
                    nextAck     = 2'b10;
                    nextState   = sThreadWait;
                end
                else
                begin
                    pcCmd = cpuIsaPkg::pcEnterIdle;
                end
            end
            // Vector byte being read from ROM
            sThreadWait:
                nextState = sThreadLoad;
            sThreadLoad:
            begin
                pcCmd     = cpuIsaPkg::pcLoad;
                nextState = sSettle;
            end

            // New ROM address needs a cycle before decode
            sSettle:
                nextState = sDecode;

            default:
                nextState = sDecode;
        endcase
    end

    // Memory data for reads, ALU result for maths
    assign regWriteData = (state == sReadStore) ? busDataIn : aluResult;

    //////////////////////////////
    // State and bus registers
    //////////////////////////////
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state        <= sDecode;
            busAddr      <= `CPU_IDLE_BUS_ADDR;
            busWrite     <= 1'b0;
            interruptAck <= '0;
        end
        else
        begin
            state        <= nextState;
            busAddr      <= nextBusAddr;
            busWrite     <= nextBusWrite;
            interruptAck <= nextAck;
        end
    end

    // Write data only matters while busWrite is high
    always_ff @(posedge CLK)
    begin
        if (state == sWriteOut)
            busDataOut <= selectedReg;
    end

endmodule

// File: source/processor.sv
`timescale 1ns/1ps

module processor
(
    input  logic            CLK,
    input  logic            RESET,
    output cpuBusPkg::addrT romAddress,
    input  cpuBusPkg::dataT romData,
    output cpuBusPkg::addrT busAddr,
    input  cpuBusPkg::dataT busDataIn,
    output cpuBusPkg::dataT busDataOut,
    output logic            busWrite,
    input  cpuBusPkg::irqT  interruptRaise,
    output cpuBusPkg::irqT  interruptAck
);

    // ROM byte, decoded as instruction or operand
    cpuIsaPkg::romWordU romWord;

    // Datapath
    cpuBusPkg::dataT    aluResult;
    cpuBusPkg::dataT    regA;
    cpuBusPkg::dataT    regB;
    cpuBusPkg::dataT    selectedReg;
    cpuBusPkg::dataT    regWriteData;

    // Control from the sequencer
    cpuIsaPkg::pcCmdT   pcCmd;
    cpuBusPkg::addrT    pcLoadValue;
    logic               selLoad;
    cpuIsaPkg::regSelT  selValue;
    logic               regWrite;

    assign romWord = cpuIsaPkg::romWordU'(romData);

    sequencer seq
    (
        .CLK            (CLK),
        .RESET          (RESET),
        .romData        (romWord),
        .aluResult      (aluResult),
        .selectedReg    (selectedReg),
        .busDataIn      (busDataIn),
        .interruptRaise (interruptRaise),
        .pcCmd          (pcCmd),
        .pcLoadValue    (pcLoadValue),
        .selLoad        (selLoad),
        .selValue       (selValue),
        .regWrite       (regWrite),
        .regWriteData   (regWriteData),
        .busAddr        (busAddr),
        .busDataOut     (busDataOut),
        .busWrite       (busWrite),
        .interruptAck   (interruptAck)
    );

    // Operation comes straight from the high nibble of the ROM byte
    alu aluInst
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .regA      (regA),
        .regB      (regB),
        .aluOp     (romWord.instr.aluOp),
        .aluResult (aluResult)
    );

    programCounter pcInst
    (
        .CLK         (CLK),
        .RESET       (RESET),
        .pcCmd       (pcCmd),
        .pcLoadValue (pcLoadValue),
        .romAddress  (romAddress)
    );

    registerFile regs
    (
        .CLK          (CLK),
        .RESET        (RESET),
        .selLoad      (selLoad),
        .selValue     (selValue),
        .regWrite     (regWrite),
        .regWriteData (regWriteData),
        .regA         (regA),
        .regB         (regB),
        .selectedReg  (selectedReg)
    );

endmodule

// File: tests/clockGen.sv
`timescale 1ns/1ps

module clockGen
(
    output logic CLK,
    output logic RESET
);

    // 8 ns period
    localparam int halfPeriod  = 4;
    localparam int resetCycles = 8;

    initial
    begin
        CLK = 1'b0;
        forever #halfPeriod CLK = ~CLK;
    end

    // Release reset just after an edge, like the other inputs
    initial
    begin
        RESET = 1'b1;
        repeat (resetCycles) @(posedge CLK);
        #1;
        RESET = 1'b0;
    end

endmodule

// File: tests/processor_asserts.sv
`timescale 1ns/1ps

module processor_asserts
(
    input logic           CLK,
    input logic           RESET,
    input logic           busWrite,
    input cpuBusPkg::irqT interruptAck
);

    // Number of property failures seen so far
    int failures = 0;

    //////////////////////////////
    // Interrupt acknowledge
    //////////////////////////////

    // Only one request accepted at a time
    ackOneHot: assert property (@(posedge CLK) disable iff (RESET) $onehot0(interruptAck))
    else
    begin
        failures++;
        $error("interruptAck has both bits set");
    end

    // Ack is a single-cycle pulse
    ackPulse: assert property (@(posedge CLK) disable iff (RESET)
        interruptAck != 2'b00 |=> interruptAck == 2'b00)
    else
    begin
        failures++;
        $error("interruptAck held for more than one cycle");
    end

    //////////////////////////////
    // Data bus
    //////////////////////////////

    // Stores are at least one instruction apart
    writeGap: assert property (@(posedge CLK) disable iff (RESET) busWrite |=> !busWrite)
    else
    begin
        failures++;
        $error("busWrite high on two consecutive cycles");
    end

    // First cycle out of reset is quiet
    quietAfterReset: assert property (@(posedge CLK)
        $fell(RESET) |-> (!busWrite && interruptAck == 2'b00))
    else
    begin
        failures++;
        $error("busWrite or interruptAck active in the cycle after reset");
    end

endmodule

// File: tests/processorTb.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module processorTb;

    localparam int driveDelay      = 1;
    localparam int threadStartCost = 4;
    localparam int tailCycles      = 20;

    logic            CLK;
    logic            RESET;
    cpuBusPkg::addrT romAddress;
    cpuBusPkg::dataT romData;
    cpuBusPkg::addrT busAddr;
    cpuBusPkg::dataT busDataIn;
    cpuBusPkg::dataT busDataOut;
    logic            busWrite;
    cpuBusPkg::irqT  interruptRaise;
    cpuBusPkg::irqT  interruptAck;

    // ROM, live memory and the model's copy of memory
    cpuBusPkg::dataT rom      [0:255];
    cpuBusPkg::dataT mem      [0:255];
    cpuBusPkg::dataT modelMem [0:255];
    cpuBusPkg::dataT modelA = '0;
    cpuBusPkg::dataT modelB = '0;

    // Predicted events in order where the kind tells a write from an ack
    bit              expIsAck [$];
    cpuBusPkg::addrT expAddr  [$];
    cpuBusPkg::dataT expData  [$];
    cpuBusPkg::irqT  expAck   [$];

    logic [31:0]     randState  = 32'hf3fb;
    int              worstCost  = 0;
    int              cycleLimit = 0;
    int              cycleCount = 0;

    // Outputs seen just before each rising edge
    cpuBusPkg::addrT romAddrSeen  = '0;
    cpuBusPkg::addrT busAddrSeen  = '0;
    logic            busWriteSeen = 1'b0;
    cpuBusPkg::dataT busDataSeen  = '0;
    cpuBusPkg::irqT  ackSeen      = '0;

    clockGen clocks
    (
        .CLK   (CLK),
        .RESET (RESET)
    );

    processor UUT
    (
        .CLK            (CLK),
        .RESET          (RESET),
        .romAddress     (romAddress),
        .romData        (romData),
        .busAddr        (busAddr),
        .busDataIn      (busDataIn),
        .busDataOut     (busDataOut),
        .busWrite       (busWrite),
        .interruptRaise (interruptRaise),
        .interruptAck   (interruptAck)
    );

    bind processor processor_asserts checks
    (
        .CLK          (CLK),
        .RESET        (RESET),
        .busWrite     (busWrite),
        .interruptAck (interruptAck)
    );

    //////////////////////////////
    // Random numbers and ISA rules
    //////////////////////////////

    // LCG whose upper half is the usable part
    function automatic logic [15:0] nextRandom();
        randState = randState * 32'd1664525 + 32'd1013904223;
        return randState[31:16];
    endfunction

    function automatic cpuBusPkg::dataT randomByte();
        logic [15:0] r;
        r = nextRandom();
        return r[7:0];
    endfunction

    // ALU as the instruction set defines it
    function automatic cpuBusPkg::dataT aluModel(input logic [3:0] fn,
                                                 input cpuBusPkg::dataT a,
                                                 input cpuBusPkg::dataT b);
        case (fn)
            4'd0:    return a + b;
            4'd1:    return a - b;
            4'd2:    return a & b;
            4'd3:    return a | b;
            4'd4:    return a ^ b;
            4'd5:    return {a[6:0], 1'b0};
            4'd6:    return {1'b0, a[7:1]};
            4'd7:    return a + 8'd1;
            4'd8:    return a - 8'd1;
            4'd9:    return (a == b) ? 8'h01 : 8'h00;
            4'd10:   return (a > b) ? 8'h01 : 8'h00;
            4'd11:   return (a < b) ? 8'h01 : 8'h00;
            default: return 8'h00;
        endcase
    endfunction

    // Maths and goto idle are one byte and the rest carry an operand
    function automatic cpuBusPkg::addrT lengthOf(input logic [3:0] kind);
        return (kind == 4'h4 || kind == 4'h5 || kind == 4'h8) ? 8'd1 : 8'd2;
    endfunction

    // Cycles from decode to next decode
    function automatic int costOf(input logic [3:0] kind);
        case (kind)
            4'h0, 4'h1: return 5;
            4'h6, 4'h7: return 4;
            4'h8:       return 2;
            default:    return 3;
        endcase
    endfunction

    //////////////////////////////
    // Program generation and model
    //////////////////////////////

    task automatic genProgram(input cpuBusPkg::addrT base, input int count, input bit isThread);
        logic [3:0]      kinds  [0:63];
        cpuBusPkg::addrT starts [0:63];
        cpuBusPkg::addrT addr;
        logic [15:0]     r;
        int              target;
        addr = base;
        // First pass fixes kinds and start addresses
        for (int i = 0; i < count; i++)
        begin
            r = nextRandom();
            if (i == count - 1)
                kinds[i] = 4'h8;
            else if (isThread && i == 0)
                kinds[i] = 4'h2;
            else if (!isThread && i < 2)
                kinds[i] = (i == 0) ? 4'h0 : 4'h1;
            else
                kinds[i] = {1'b0, r[2:0]};
            starts[i] = addr;
            addr = addr + lengthOf(kinds[i]);
            worstCost += costOf(kinds[i]);
        end
        // Second pass fills bytes with forward-only jumps
        for (int i = 0; i < count; i++)
        begin
            r = nextRandom();
            if (kinds[i] == 4'h6)
                rom[starts[i]] = {4'h9 + r[3:0] % 4'd3, 4'h6};
            else
                rom[starts[i]] = {r[3:0], kinds[i]};
            if (kinds[i] == 4'h6 || kinds[i] == 4'h7)
            begin
                target = i + 1 + int'(r[7:4] % 4'd3);
                if (target > count - 1)
                    target = count - 1;
                rom[starts[i] + 8'd1] = starts[target];
            end
            else if (lengthOf(kinds[i]) == 8'd2)
            begin
                rom[starts[i] + 8'd1] = randomByte();
            end
        end
    endtask

    task automatic expectWrite(input cpuBusPkg::addrT addr, input cpuBusPkg::dataT data);
        expIsAck.push_back(1'b0);
        expAddr.push_back(addr);
        expData.push_back(data);
        modelMem[addr] = data;
    endtask

    task automatic expectAck(input cpuBusPkg::irqT ack);
        expIsAck.push_back(1'b1);
        expAck.push_back(ack);
    endtask

    // Instruction-level run until goto idle
    task automatic runModel(input cpuBusPkg::addrT start);
        cpuBusPkg::addrT pc;
        cpuBusPkg::addrT operand;
        logic [3:0]      op;
        logic [3:0]      fn;
        bit              done;
        pc = start;
        done = 1'b0;
        while (!done)
        begin
            op = rom[pc][3:0];
            fn = rom[pc][7:4];
            operand = rom[pc + 8'd1];
            case (op)
                4'h0:
                begin
                    modelA = modelMem[operand];
                    pc = pc + 8'd2;
                end
                4'h1:
                begin
                    modelB = modelMem[operand];
                    pc = pc + 8'd2;
                end
                4'h2:
                begin
                    expectWrite(operand, modelA);
                    pc = pc + 8'd2;
                end
                4'h3:
                begin
                    expectWrite(operand, modelB);
                    pc = pc + 8'd2;
                end
                4'h4:
                begin
                    modelA = aluModel(fn, modelA, modelB);
                    pc = pc + 8'd1;
                end
                4'h5:
                begin
                    modelB = aluModel(fn, modelA, modelB);
                    pc = pc + 8'd1;
                end
                4'h6:    pc = (aluModel(fn, modelA, modelB) == 8'h01) ? operand : pc + 8'd2;
                4'h7:    pc = operand;
                4'h8:    done = 1'b1;
                default: pc = pc + 8'd1;
            endcase
        end
    endtask

    //////////////////////////////
    // Checks
    //////////////////////////////

    task automatic stopRun(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic checkWrite(input cpuBusPkg::addrT addr, input cpuBusPkg::dataT data);
        if (expIsAck.size() == 0 || expIsAck[0])
            stopRun($sformatf("Unexpected bus write of %h to address %h", data, addr));
        else if (addr !== expAddr[0] || data !== expData[0])
            stopRun($sformatf("Fail at %0t: write %h to %h, expected %h to %h",
                              $time, data, addr, expData[0], expAddr[0]));
        else
        begin
            void'(expIsAck.pop_front());
            void'(expAddr.pop_front());
            void'(expData.pop_front());
        end
    endtask

    task automatic checkAck(input cpuBusPkg::irqT ack);
        if (expIsAck.size() == 0 || !expIsAck[0])
            stopRun($sformatf("Unexpected interrupt acknowledge %b", ack));
        else if (ack !== expAck[0])
            stopRun($sformatf("Fail at %0t: interruptAck %b, expected %b", $time, ack, expAck[0]));
        else
        begin
            void'(expIsAck.pop_front());
            void'(expAck.pop_front());
        end
    endtask

    task automatic checkAddress(input string what, input cpuBusPkg::addrT got,
                                input cpuBusPkg::addrT expected);
        if (got !== expected)
            stopRun($sformatf("Fail at %0t: %s is %h, expected %h", $time, what, got, expected));
    endtask

    //////////////////////////////
    // ROM, memory and interrupt source
    //////////////////////////////

    always @(negedge CLK)
    begin
        romAddrSeen  = romAddress;
        busAddrSeen  = busAddr;
        busWriteSeen = busWrite;
        busDataSeen  = busDataOut;
        ackSeen      = interruptAck;
    end

    // One cycle latency on ROM and memory
    always @(posedge CLK)
    begin
        #driveDelay;
        romData = rom[romAddrSeen];
        if (busWriteSeen)
            mem[busAddrSeen] = busDataSeen;
        busDataIn = mem[busAddrSeen];
        // Request drops once its ack has been seen
        interruptRaise = interruptRaise & ~ackSeen;
    end

    // Observed writes and acks
    always @(negedge CLK)
    begin
        if (!RESET && busWrite)
            checkWrite(busAddr, busDataOut);
        else if (!RESET && interruptAck != 2'b00)
            checkAck(interruptAck);
    end

    // Bound protocol properties
    always @(UUT.checks.failures)
    begin
        if (UUT.checks.failures != 0)
            stopRun("A bound assertion on the processor outputs failed");
    end

    always @(posedge CLK)
    begin
        cycleCount++;
        if (cycleCount > cycleLimit)
            stopRun($sformatf("Timeout after %0d cycles, program did not finish", cycleCount));
    end

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial
    begin
        romData        = '0;
        busDataIn      = '0;
        interruptRaise = 2'b11;

        for (int i = 0; i < 256; i++)
        begin
            mem[i]      = randomByte();
            modelMem[i] = mem[i];
            rom[i]      = randomByte();
        end
        genProgram(8'h00, 64, 1'b0);
        genProgram(8'hA0, 6, 1'b1);
        genProgram(8'hC0, 6, 1'b1);
        rom[`CPU_VECTOR_A] = 8'hA0;
        rom[`CPU_VECTOR_B] = 8'hC0;
        cycleLimit = 10 * (worstCost + 2 * threadStartCost);

        // Both lines raised, so A runs before B
        runModel(`CPU_RESET_PC);
        expectAck(2'b01);
        runModel(rom[`CPU_VECTOR_A]);
        expectAck(2'b10);
        runModel(rom[`CPU_VECTOR_B]);

        wait (RESET == 1'b0);
        @(negedge CLK);
        if (busWrite !== 1'b0 || interruptAck !== 2'b00)
            stopRun($sformatf("Fail at %0t: busWrite %b, interruptAck %b right after reset",
                              $time, busWrite, interruptAck));
        checkAddress("busAddr", busAddr, `CPU_IDLE_BUS_ADDR);
        checkAddress("romAddress", romAddress, `CPU_RESET_PC);

        while (expIsAck.size() != 0)
            @(negedge CLK);
        // Extra idle cycles in which no further write or ack may appear
        repeat (tailCycles) @(negedge CLK);

        // Parked on the idle location with the bus released
        checkAddress("busAddr", busAddr, `CPU_IDLE_BUS_ADDR);
        if (romAddress !== `CPU_IDLE_PC)
            stopRun($sformatf("Fail at %0t: romAddress is %h, expected idle address %h",
                              $time, romAddress, `CPU_IDLE_PC));
        else
        begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

// File: verilog.f
+incdir+source
source/cpuBusPkg.sv
source/cpuIsaPkg.sv
source/alu.sv
source/programCounter.sv
source/registerFile.sv
source/sequencer.sv
source/processor.sv
tests/clockGen.sv
tests/processor_asserts.sv
tests/processorTb.sv
